// ==== logic/recovery_pkg.sv ====
`default_nettype none

package recovery_pkg;

    // instruction address
    typedef logic [31:0] addr_t;

    // register file sizes, they set the index widths below
    localparam int arch_regs = 8;
    localparam int phys_regs = 16;

    typedef logic [$clog2(arch_regs)-1:0] arch_idx_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_idx_t;

    // one rename map entry, physical tag plus ready bit
    typedef struct packed {
        phys_idx_t phys;
        logic      ready;
    } map_entry_t;

    // whole map table, indexed by architectural register
    typedef map_entry_t [arch_regs-1:0] map_table_t;

    // default number of checkpoint slots, also the id width of a saved record
    localparam int slot_count = 4;

    // free list head and rob tail pointers
    typedef logic [$clog2(phys_regs):0] fl_ptr_t;
    typedef logic [3:0] rob_ptr_t;

    // fall-through distance for a not-taken branch
    localparam addr_t pc_step = 32'd4;

    // class of a dispatched operation
    typedef enum logic [1:0] {
        op_nop    = 2'd0,
        op_alu    = 2'd1,
        op_branch = 2'd2,
        op_jump   = 2'd3
    } op_t;

    // action the resolve stage asks of the checkpoint stack
    typedef enum logic [1:0] {
        task_none   = 2'd0,
        task_clear  = 2'd1,
        task_squash = 2'd2
    } br_task_t;

    // one checkpoint slot
    // b_id is one-hot, b_mask holds this id plus every older branch still in flight
    typedef struct packed {
        logic                  valid;
        logic [slot_count-1:0] b_id;
        logic [slot_count-1:0] b_mask;
        addr_t                 rec_pc;
        map_table_t            rec_map;
        fl_ptr_t               fl_head;
        rob_ptr_t              rob_tail;
    } checkpoint_t;

endpackage

`default_nettype wire

// ==== logic/checkpoint_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface checkpoint_if #(
    parameter int depth = recovery_pkg::slot_count
);
    import recovery_pkg::*;

    // capture request from decode
    logic       valid_assign;
    addr_t      pc;
    map_table_t map;
    fl_ptr_t    fl_head;
    rob_ptr_t   rob_tail;
    logic       predicted_taken;

    // slot state returned by the stack
    logic [depth-1:0] grant;
    logic             full;

    modport decode_side (
        output valid_assign, pc, map, fl_head, rob_tail, predicted_taken,
        input  grant, full
    );

    modport stack_side (
        input  valid_assign, pc, map, fl_head, rob_tail,
        output grant, full
    );

    modport resolve_side (
        input valid_assign, grant, predicted_taken
    );

endinterface

`default_nettype wire

// ==== logic/branch_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_decode #(
    parameter int depth = recovery_pkg::slot_count
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   dispatch_valid,
    input  recovery_pkg::op_t      dispatch_op,
    input  recovery_pkg::addr_t    dispatch_pc,
    input  logic                   predicted_taken,
    input  recovery_pkg::map_table_t map_in,
    input  recovery_pkg::fl_ptr_t  fl_head_in,
    input  recovery_pkg::rob_ptr_t rob_tail_in,
    checkpoint_if.decode_side      cap,
    output logic                   stall,
    output logic [depth-1:0]       assigned_id
);
    import recovery_pkg::*;

    logic needs_checkpoint;

    // only conditional branches are predicted and save state
    always_comb begin
        needs_checkpoint = 1'b0;
        unique case (dispatch_op)
            op_branch: needs_checkpoint = dispatch_valid;
            op_nop, op_alu, op_jump: needs_checkpoint = 1'b0;
            default: needs_checkpoint = 1'b0;
        endcase
    end

    assign cap.valid_assign = needs_checkpoint && !cap.full;
    assign stall = needs_checkpoint && cap.full;

    // rename snapshot rides along with every request
    assign cap.pc = dispatch_pc;
    assign cap.map = map_in;
    assign cap.fl_head = fl_head_in;
    assign cap.rob_tail = rob_tail_in;
    assign cap.predicted_taken = predicted_taken;

    // the granted slot becomes the branch tag of this dispatch
    assign assigned_id = cap.valid_assign ? cap.grant : '0;

    // a request must land on exactly one slot granted by the stack
    assert property (@(posedge clock) disable iff (reset)
        cap.valid_assign |-> $onehot(cap.grant))
        else $error("capture requested without a single granted slot");

endmodule

`default_nettype wire

// ==== logic/checkpoint_stack.sv ====
`timescale 1ns/10ps
`default_nettype none

module checkpoint_stack #(
    parameter int depth = recovery_pkg::slot_count
) (
    input  logic                    clock,
    input  logic                    reset,
    checkpoint_if.stack_side        cap,
    input  logic                    cdb_valid,
    input  recovery_pkg::arch_idx_t cdb_arch,
    input  recovery_pkg::phys_idx_t cdb_phys,
    input  recovery_pkg::br_task_t  br_task,
    input  logic [depth-1:0]        rem_b_id,
    output recovery_pkg::checkpoint_t cp_out
);
    import recovery_pkg::*;

    // saved ids are slot_count wide, so depth may not exceed it
    if (depth > slot_count) begin : g_depth_check
        $error("depth %0d exceeds slot_count %0d", depth, slot_count);
    end

    checkpoint_t [depth-1:0] entries;
    checkpoint_t [depth-1:0] next_entries;

    logic [depth-1:0]      valid_vec;
    logic [depth-1:0]      free_map;
    logic [depth-1:0]      grant_vec;
    logic [depth-1:0]      live_vec;
    logic [slot_count-1:0] rem_id;

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            valid_vec[i] = entries[i].valid;
        end
    end

    assign free_map = ~valid_vec;
    assign rem_id = slot_count'(rem_b_id);

    // lowest free slot wins
    always_comb begin
        grant_vec = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (free_map[i]) begin
                grant_vec = '0;
                grant_vec[i] = 1'b1;
            end
        end
    end

    assign cap.grant = grant_vec;
    assign cap.full = ~|free_map;

    always_comb begin
        next_entries = entries;
        cp_out = '0;

        if (br_task == task_squash) begin
            for (int i = 0; i < depth; i++) begin
                if (entries[i].valid && entries[i].b_id == rem_id) begin
                    cp_out = entries[i];
                end
                // the branch itself and everything younger carry its bit
                if (entries[i].valid && |(entries[i].b_mask & rem_id)) begin
                    next_entries[i].valid = 1'b0;
                    next_entries[i].b_mask = '0;
                end
            end
        end else if (br_task == task_clear) begin
            for (int i = 0; i < depth; i++) begin
                if (entries[i].valid && entries[i].b_id == rem_id) begin
                    next_entries[i].valid = 1'b0;
                    next_entries[i].b_mask = '0;
                end else begin
                    next_entries[i].b_mask = entries[i].b_mask & ~rem_id;
                end
            end
        end

        // slots still in flight after this cycle's release
        for (int i = 0; i < depth; i++) begin
            live_vec[i] = next_entries[i].valid;
        end

        // a capture that races a squash is younger, so it is dropped
        if (cap.valid_assign && br_task != task_squash) begin
            for (int k = 0; k < depth; k++) begin
                if (grant_vec[k]) begin
                    next_entries[k].valid = 1'b1;
                    next_entries[k].b_id = slot_count'(grant_vec);
                    next_entries[k].b_mask = slot_count'(live_vec | grant_vec);
                    next_entries[k].rec_pc = cap.pc;
                    next_entries[k].rec_map = cap.map;
                    next_entries[k].fl_head = cap.fl_head;
                    next_entries[k].rob_tail = cap.rob_tail;
                end
            end
        end

        // wakeup covers a slot captured in this same cycle
        if (cdb_valid) begin
            for (int j = 0; j < depth; j++) begin
                if (next_entries[j].valid &&
                    next_entries[j].rec_map[cdb_arch].phys == cdb_phys) begin
                    next_entries[j].rec_map[cdb_arch].ready = 1'b1;
                end
            end
        end

        // forward a broadcast that lands while the map is being restored
        if (cdb_valid && cp_out.valid && cp_out.rec_map[cdb_arch].phys == cdb_phys) begin
            cp_out.rec_map[cdb_arch].ready = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].b_id <= '0;
                entries[i].b_mask <= '0;
            end
        end else begin
            entries <= next_entries;
        end
    end

    // resolve must name exactly one branch that is still in flight here
    assert property (@(posedge clock) disable iff (reset)
        br_task != task_none |-> $onehot(rem_b_id) && |(rem_b_id & valid_vec))
        else $error("branch task names a free or malformed slot id");

endmodule

`default_nettype wire

// ==== logic/branch_resolve.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_resolve #(
    parameter int depth = recovery_pkg::slot_count
) (
    input  logic                      clock,
    input  logic                      reset,
    checkpoint_if.resolve_side        cap,
    input  logic                      resolve_valid,
    input  logic [depth-1:0]          resolve_b_id,
    input  logic                      resolve_taken,
    input  recovery_pkg::addr_t       resolve_target,
    input  recovery_pkg::checkpoint_t cp_in,
    output recovery_pkg::br_task_t    br_task,
    output logic [depth-1:0]          rem_b_id,
    output logic                      recover_valid,
    output recovery_pkg::addr_t       recover_pc
);
    import recovery_pkg::*;

    // prediction per slot, written when the slot is granted
    logic [depth-1:0] pred_taken;
    logic             predicted;
    addr_t            target_q;
    logic             taken_q;

    always_ff @(posedge clock) begin
        if (cap.valid_assign) begin
            pred_taken <= (pred_taken & ~cap.grant) | (cap.grant & {depth{cap.predicted_taken}});
        end
    end

    assign predicted = |(pred_taken & resolve_b_id);

    always_ff @(posedge clock) begin
        if (reset) begin
            br_task <= task_none;
            rem_b_id <= '0;
        end else if (resolve_valid) begin
            br_task <= (resolve_taken != predicted) ? task_squash : task_clear;
            rem_b_id <= resolve_b_id;
        end else begin
            br_task <= task_none;
            rem_b_id <= '0;
        end
    end

    // redirect data, only looked at during a squash
    always_ff @(posedge clock) begin
        if (resolve_valid) begin
            target_q <= resolve_target;
            taken_q <= resolve_taken;
        end
    end

    assign recover_valid = br_task == task_squash;
    assign recover_pc = taken_q ? target_q : cp_in.rec_pc + pc_step;

    // the execute stage reports one branch tag per resolution
    assert property (@(posedge clock) disable iff (reset)
        resolve_valid |-> $onehot(resolve_b_id))
        else $error("resolve tag is not one-hot");

endmodule

`default_nettype wire

// ==== logic/recovery_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module recovery_top #(
    parameter int depth = recovery_pkg::slot_count
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  recovery_pkg::op_t        dispatch_op,
    input  recovery_pkg::addr_t      dispatch_pc,
    input  logic                     predicted_taken,
    input  recovery_pkg::map_table_t map_in,
    input  recovery_pkg::fl_ptr_t    fl_head_in,
    input  recovery_pkg::rob_ptr_t   rob_tail_in,
    input  logic                     cdb_valid,
    input  recovery_pkg::arch_idx_t  cdb_arch,
    input  recovery_pkg::phys_idx_t  cdb_phys,
    input  logic                     resolve_valid,
    input  logic [depth-1:0]         resolve_b_id,
    input  logic                     resolve_taken,
    input  recovery_pkg::addr_t      resolve_target,
    output logic                     stall,
    output logic [depth-1:0]         assigned_id,
    output logic                     recover_valid,
    output recovery_pkg::addr_t      recover_pc,
    output recovery_pkg::map_table_t recover_map,
    output recovery_pkg::fl_ptr_t    recover_fl_head,
    output recovery_pkg::rob_ptr_t   recover_rob_tail
);
    import recovery_pkg::*;

    br_task_t         br_task;
    logic [depth-1:0] rem_b_id;
    checkpoint_t      cp_out;

    checkpoint_if #(.depth(depth)) cap_if ();

    branch_decode #(.depth(depth)) decode_inst (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .dispatch_pc(dispatch_pc), .predicted_taken(predicted_taken),
        .map_in(map_in), .fl_head_in(fl_head_in), .rob_tail_in(rob_tail_in),
        .cap(cap_if.decode_side), .stall(stall), .assigned_id(assigned_id)
    );

    checkpoint_stack #(.depth(depth)) stack_inst (
        .clock(clock), .reset(reset), .cap(cap_if.stack_side),
        .cdb_valid(cdb_valid), .cdb_arch(cdb_arch), .cdb_phys(cdb_phys),
        .br_task(br_task), .rem_b_id(rem_b_id), .cp_out(cp_out)
    );

    branch_resolve #(.depth(depth)) resolve_inst (
        .clock(clock), .reset(reset), .cap(cap_if.resolve_side),
        .resolve_valid(resolve_valid), .resolve_b_id(resolve_b_id),
        .resolve_taken(resolve_taken), .resolve_target(resolve_target),
        .cp_in(cp_out), .br_task(br_task), .rem_b_id(rem_b_id),
        .recover_valid(recover_valid), .recover_pc(recover_pc)
    );

    // restored rename state comes straight from the squashed slot
    assign recover_map = cp_out.rec_map;
    assign recover_fl_head = cp_out.fl_head;
    assign recover_rob_tail = cp_out.rob_tail;

endmodule

`default_nettype wire

// ==== test/recovery_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module recovery_checker #(
    parameter int depth = recovery_pkg::slot_count
) (
    input  logic                     clock,
    input  logic                     check_en,
    input  logic [8*12-1:0]          step_name,
    input  logic                     exp_stall,
    input  logic [depth-1:0]         exp_id,
    input  logic                     exp_recover,
    input  recovery_pkg::addr_t      exp_pc,
    input  recovery_pkg::map_table_t exp_map,
    input  recovery_pkg::fl_ptr_t    exp_fl_head,
    input  recovery_pkg::rob_ptr_t   exp_rob_tail,
    input  logic                     stall,
    input  logic [depth-1:0]         assigned_id,
    input  logic                     recover_valid,
    input  recovery_pkg::addr_t      recover_pc,
    input  recovery_pkg::map_table_t recover_map,
    input  recovery_pkg::fl_ptr_t    recover_fl_head,
    input  recovery_pkg::rob_ptr_t   recover_rob_tail,
    output int                       check_count,
    output int                       error_count
);
    import recovery_pkg::*;

    initial begin
        check_count = 0;
        error_count = 0;
    end

    task automatic compare_field(input logic [8*12-1:0] field, input logic [63:0] expected,
                                 input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s %s expected %h actual %h", step_name, field, expected, actual);
        end
    endtask

    // inputs settle on the falling edge, so the rising edge sees stable values
    always @(posedge clock) begin
        if (check_en) begin
            compare_field("stall", 64'(exp_stall), 64'(stall));
            compare_field("assigned_id", 64'(exp_id), 64'(assigned_id));
            compare_field("recover", 64'(exp_recover), 64'(recover_valid));
            // restored state only means something during a squash
            if (exp_recover) begin
                compare_field("recover_pc", 64'(exp_pc), 64'(recover_pc));
                compare_field("recover_map", 64'(exp_map), 64'(recover_map));
                compare_field("fl_head", 64'(exp_fl_head), 64'(recover_fl_head));
                compare_field("rob_tail", 64'(exp_rob_tail), 64'(recover_rob_tail));
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/recovery_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module recovery_tb;
    import recovery_pkg::*;

    localparam int depth = slot_count;
    localparam int clock_period = 4;
    localparam int reset_cycles = 5;
    localparam int max_steps = 24;
    localparam int margin_cycles = 20;
    localparam int branch_count = 10;

    // one table row with stimulus first and expected outputs after it
    typedef struct packed {
        logic [8*12-1:0]  name;
        logic             dv;
        op_t              op;
        addr_t            pc;
        logic             pred;
        map_table_t       map;
        fl_ptr_t          fl;
        rob_ptr_t         rob;
        logic             cdb_v;
        arch_idx_t        cdb_a;
        phys_idx_t        cdb_p;
        logic             res_v;
        logic [depth-1:0] res_id;
        logic             res_taken;
        addr_t            res_tgt;
        logic             e_stall;
        logic [depth-1:0] e_id;
        logic             e_rv;
        addr_t            e_pc;
        map_table_t       e_map;
        fl_ptr_t          e_fl;
        rob_ptr_t         e_rob;
    } step_t;

    logic             clock;
    logic             reset;
    logic             check_en;
    step_t            applied;
    step_t            cur;
    step_t            steps [max_steps];
    int               step_total;
    int               check_count;
    int               error_count;
    int unsigned      seed;
    int unsigned      rnd;
    logic             stall;
    logic [depth-1:0] assigned_id;
    logic             recover_valid;
    addr_t            recover_pc;
    map_table_t       recover_map;
    fl_ptr_t          recover_fl_head;
    rob_ptr_t         recover_rob_tail;
    arch_idx_t        wk_arch;
    phys_idx_t        wk_phys;

    // rename snapshot per dispatched branch in dispatch order
    addr_t      br_pc [branch_count];
    addr_t      br_tgt [branch_count];
    map_table_t br_map [branch_count];
    fl_ptr_t    br_fl [branch_count];
    rob_ptr_t   br_rob [branch_count];

    recovery_top #(.depth(depth)) recovery_top_inst (
        .clock(clock), .reset(reset),
        .dispatch_valid(applied.dv), .dispatch_op(applied.op), .dispatch_pc(applied.pc),
        .predicted_taken(applied.pred), .map_in(applied.map),
        .fl_head_in(applied.fl), .rob_tail_in(applied.rob),
        .cdb_valid(applied.cdb_v), .cdb_arch(applied.cdb_a), .cdb_phys(applied.cdb_p),
        .resolve_valid(applied.res_v), .resolve_b_id(applied.res_id),
        .resolve_taken(applied.res_taken), .resolve_target(applied.res_tgt),
        .stall(stall), .assigned_id(assigned_id), .recover_valid(recover_valid),
        .recover_pc(recover_pc), .recover_map(recover_map),
        .recover_fl_head(recover_fl_head), .recover_rob_tail(recover_rob_tail)
    );

    recovery_checker #(.depth(depth)) checker_inst (
        .clock(clock), .check_en(check_en), .step_name(applied.name),
        .exp_stall(applied.e_stall), .exp_id(applied.e_id), .exp_recover(applied.e_rv),
        .exp_pc(applied.e_pc), .exp_map(applied.e_map),
        .exp_fl_head(applied.e_fl), .exp_rob_tail(applied.e_rob),
        .stall(stall), .assigned_id(assigned_id), .recover_valid(recover_valid),
        .recover_pc(recover_pc), .recover_map(recover_map),
        .recover_fl_head(recover_fl_head), .recover_rob_tail(recover_rob_tail),
        .check_count(check_count), .error_count(error_count)
    );

    always #2 clock = ~clock;

    function automatic map_table_t rand_map();
        map_table_t m;
        for (int i = 0; i < arch_regs; i++) begin
            m[i].phys = phys_idx_t'($urandom);
            m[i].ready = 1'($urandom);
        end
        return m;
    endfunction

    // a broadcast sets ready where the saved tag matches
    function automatic map_table_t woken(input map_table_t m);
        map_table_t w;
        w = m;
        if (w[wk_arch].phys == wk_phys) begin
            w[wk_arch].ready = 1'b1;
        end
        return w;
    endfunction

    task automatic push_step(input logic [8*12-1:0] name);
        cur.name = name;
        steps[step_total] = cur;
        step_total++;
        cur = '0;
    endtask

    task automatic branch_step(input logic [8*12-1:0] name, input int k, input logic pred,
                               input logic e_stall, input logic [depth-1:0] e_id);
        cur.dv = 1'b1;
        cur.op = op_branch;
        cur.pc = br_pc[k];
        cur.pred = pred;
        cur.map = br_map[k];
        cur.fl = br_fl[k];
        cur.rob = br_rob[k];
        cur.e_stall = e_stall;
        cur.e_id = e_id;
        push_step(name);
    endtask

    task automatic resolve_step(input logic [8*12-1:0] name, input logic [depth-1:0] id,
                                input logic taken, input addr_t target);
        cur.res_v = 1'b1;
        cur.res_id = id;
        cur.res_taken = taken;
        cur.res_tgt = target;
        push_step(name);
    endtask

    // recovery shows up one cycle after the resolve
    task automatic expect_recovery(input int k, input addr_t rpc);
        cur.e_rv = 1'b1;
        cur.e_pc = rpc;
        cur.e_map = woken(br_map[k]);
        cur.e_fl = br_fl[k];
        cur.e_rob = br_rob[k];
    endtask

    task automatic build_table();
        cur = '0;
        step_total = 0;
        cur.dv = 1'b1;
        cur.op = op_alu;
        cur.pc = br_pc[0] - 32'd4;
        push_step("alu_op");
        branch_step("br_a", 0, 1'b0, 1'b0, 4'b0001);
        branch_step("br_b", 1, 1'b1, 1'b0, 4'b0010);
        branch_step("br_c", 2, 1'b1, 1'b0, 4'b0100);
        branch_step("br_d", 3, 1'b0, 1'b0, 4'b1000);
        branch_step("br_full", 4, 1'b0, 1'b1, 4'b0000);
        resolve_step("res_d_ok", 4'b1000, 1'b0, br_tgt[3]);
        push_step("clear_d");
        branch_step("br_e", 5, 1'b1, 1'b0, 4'b1000);
        resolve_step("res_c_ok", 4'b0100, 1'b1, br_tgt[2]);
        push_step("clear_c");
        cur.cdb_v = 1'b1;
        cur.cdb_a = wk_arch;
        cur.cdb_p = wk_phys;
        push_step("wakeup");
        // b predicted taken but falls through
        resolve_step("res_b_bad", 4'b0010, 1'b0, br_tgt[1]);
        expect_recovery(1, br_pc[1] + 32'd4);
        // this dispatch races the squash and must be dropped
        branch_step("squash_b", 6, 1'b0, 1'b0, 4'b0100);
        branch_step("br_f", 7, 1'b0, 1'b0, 4'b0010);
        branch_step("br_g", 8, 1'b0, 1'b0, 4'b0100);
        resolve_step("res_a_bad", 4'b0001, 1'b1, br_tgt[0]);
        expect_recovery(0, br_tgt[0]);
        push_step("squash_a");
        branch_step("br_h", 9, 1'b0, 1'b0, 4'b0001);
        push_step("idle");
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        check_en = 1'b0;
        applied = '0;
        seed = 32'hb21a03f1;
        rnd = $urandom(seed);
        for (int k = 0; k < branch_count; k++) begin
            br_pc[k] = $urandom & 32'hffff_fffc;
            br_tgt[k] = $urandom & 32'hffff_fffc;
            br_map[k] = rand_map();
            br_fl[k] = fl_ptr_t'($urandom);
            br_rob[k] = rob_ptr_t'($urandom);
        end
        // broadcast targets branch b whose entry starts not ready
        wk_arch = arch_idx_t'(rnd);
        br_map[1][wk_arch].ready = 1'b0;
        wk_phys = br_map[1][wk_arch].phys;
        build_table();

        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int i = 0; i < step_total; i++) begin
            @(negedge clock);
            applied = steps[i];
            check_en = 1'b1;
        end
        @(negedge clock);
        applied = '0;
        check_en = 1'b0;
        repeat (2) @(negedge clock);
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #((max_steps + reset_cycles + margin_cycles) * clock_period);
        $display("run timed out before all steps were applied");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/recovery_pkg.sv
logic/checkpoint_if.sv
logic/branch_decode.sv
logic/checkpoint_stack.sv
logic/branch_resolve.sv
logic/recovery_top.sv
test/recovery_checker.sv
test/recovery_tb.sv
